// File: list.f
rtl/bit_width_pkg.sv
rtl/bit_op_pkg.sv
rtl/barrel_shifter.sv
rtl/bit_counter.sv
rtl/bit_result_select.sv
rtl/bit_unit.sv
verif/bit_unit_assertions.sv
verif/bit_unit_tb.sv

// File: rtl/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter (
    input  bit_width_pkg::word_t  d,      // Word to shift or rotate
    input  bit_width_pkg::shamt_t shift,  // Distance 0 to 31
    input  logic                  dir,    // 0 left, 1 right
    input  logic                  mode,   // 0 shift, 1 rotate
    output bit_width_pkg::word_t  y
);

    import bit_width_pkg::*;

    // Output of each power-of-two stage
    word_t stage [5];

    // In every stage the bits that leave one end come back at the other end
    // when rotating, and are masked to zero when shifting

    // Move by 1
    always_comb begin
        stage[0] = d;
        if (shift[0]) begin
            if (!dir) begin
                stage[0] = {d[WORD_BITS-2:0], mode & d[WORD_BITS-1]};
            end else begin
                stage[0] = {mode & d[0], d[WORD_BITS-1:1]};
            end
        end
    end

    // Move by 2
    always_comb begin
        stage[1] = stage[0];
        if (shift[1]) begin
            if (!dir) begin
                stage[1] = {stage[0][WORD_BITS-3:0],
                            {2{mode}} & stage[0][WORD_BITS-1:WORD_BITS-2]};
            end else begin
                stage[1] = {{2{mode}} & stage[0][1:0],
                            stage[0][WORD_BITS-1:2]};
            end
        end
    end

    // Move by 4
    always_comb begin
        stage[2] = stage[1];
        if (shift[2]) begin
            if (!dir) begin
                stage[2] = {stage[1][WORD_BITS-5:0],
                            {4{mode}} & stage[1][WORD_BITS-1:WORD_BITS-4]};
            end else begin
                stage[2] = {{4{mode}} & stage[1][3:0],
                            stage[1][WORD_BITS-1:4]};
            end
        end
    end

    // Move by 8
    always_comb begin
        stage[3] = stage[2];
        if (shift[3]) begin
            if (!dir) begin
                stage[3] = {stage[2][WORD_BITS-9:0],
                            {8{mode}} & stage[2][WORD_BITS-1:WORD_BITS-8]};
            end else begin
                stage[3] = {{8{mode}} & stage[2][7:0],
                            stage[2][WORD_BITS-1:8]};
            end
        end
    end

    // Move by 16, half the word so both rotate directions agree
    always_comb begin
        stage[4] = stage[3];
        if (shift[4]) begin
            if (!dir) begin
                stage[4] = {stage[3][WORD_BITS-17:0],
                            {16{mode}} & stage[3][WORD_BITS-1:WORD_BITS-16]};
            end else begin
                stage[4] = {{16{mode}} & stage[3][15:0],
                            stage[3][WORD_BITS-1:16]};
            end
        end
    end

    assign y = stage[4];

endmodule

// File: rtl/bit_counter.sv
`timescale 1ns/1ps

module bit_counter (
    input  bit_width_pkg::word_t  d,
    input  logic [1:0]            sel,    // 00 clz, 01 ctz, 1x pop
    output bit_width_pkg::count_t count
);

    import bit_width_pkg::*;

    count_t lead_zeros;
    count_t trail_zeros;
    count_t pop_count;

    // Population adder tree, each level one bit wider
    logic [1:0] sum2  [16];
    logic [2:0] sum4  [8];
    logic [3:0] sum8  [4];
    logic [4:0] sum16 [2];

    // First set bit seen from the top decides the count
    always_comb begin
        logic hit;
        hit        = 1'b0;
        lead_zeros = count_t'(WORD_BITS);  // Zero operand
        for (int i = WORD_BITS - 1; i >= 0; i--) begin
            if (!hit && d[i]) begin
                lead_zeros = count_t'(WORD_BITS - 1 - i);
                hit        = 1'b1;
            end
        end
    end

    // Same scan from the bottom
    always_comb begin
        logic hit;
        hit         = 1'b0;
        trail_zeros = count_t'(WORD_BITS);
        for (int i = 0; i < WORD_BITS; i++) begin
            if (!hit && d[i]) begin
                trail_zeros = count_t'(i);
                hit         = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            sum2[i] = {1'b0, d[2*i]} + {1'b0, d[2*i+1]};
        end
        for (int i = 0; i < 8; i++) begin
            sum4[i] = {1'b0, sum2[2*i]} + {1'b0, sum2[2*i+1]};
        end
        for (int i = 0; i < 4; i++) begin
            sum8[i] = {1'b0, sum4[2*i]} + {1'b0, sum4[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            sum16[i] = {1'b0, sum8[2*i]} + {1'b0, sum8[2*i+1]};
        end
        pop_count = {1'b0, sum16[0]} + {1'b0, sum16[1]};
    end

    always_comb begin
        if (sel[1]) begin
            count = pop_count;    // Also covers the reserved code
        end else if (sel[0]) begin
            count = trail_zeros;
        end else begin
            count = lead_zeros;
        end
    end

endmodule

// File: rtl/bit_op_pkg.sv
package bit_op_pkg;

    localparam int OP_BITS = 3;

    typedef logic [OP_BITS-1:0] op_t;

    // Field positions inside an operation code
    localparam int OP_DIR_BIT   = 0;  // 0 left, 1 right
    localparam int OP_MODE_BIT  = 1;  // 0 shift, 1 rotate
    localparam int OP_CLASS_BIT = 2;  // 0 shifter, 1 counter

    // Shifter class
    localparam op_t OP_SLL = 3'b000;
    localparam op_t OP_SRL = 3'b001;
    localparam op_t OP_ROL = 3'b010;
    localparam op_t OP_ROR = 3'b011;

    // Counter class, the two low bits select the count
    // Code 111 is reserved and decodes as population count
    localparam op_t OP_CLZ = 3'b100;
    localparam op_t OP_CTZ = 3'b101;
    localparam op_t OP_POP = 3'b110;

endpackage

// File: rtl/bit_result_select.sv
`timescale 1ns/1ps

module bit_result_select (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,    // One operation per high cycle
    input  bit_op_pkg::op_t       op,
    input  bit_width_pkg::word_t  shifted,  // From the barrel shifter
    input  bit_width_pkg::count_t count,    // From the bit counter
    output bit_width_pkg::word_t  result,
    output logic                  zero,
    output logic                  done
);

    import bit_width_pkg::*;
    import bit_op_pkg::*;

    word_t chosen;

    // Counts are zero-extended to a full word
    always_comb begin
        if (op[OP_CLASS_BIT]) begin
            chosen = word_t'(count);
        end else begin
            chosen = shifted;
        end
    end

    // Capture on the start edge, hold until the next start
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            zero   <= 1'b1;   // Matches the cleared result
        end else if (start) begin
            result <= chosen;
            zero   <= (chosen == '0);
        end
    end

    // Done marks the cycle after each start
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

endmodule

// File: rtl/bit_unit.sv
`timescale 1ns/1ps

module bit_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  bit_op_pkg::op_t       op,
    input  bit_width_pkg::word_t  operand,
    input  bit_width_pkg::shamt_t shamt,
    output bit_width_pkg::word_t  result,
    output logic                  zero,
    output logic                  done
);

    import bit_width_pkg::*;
    import bit_op_pkg::*;

    word_t  shifted;   // Shifter output
    count_t count;     // Counter output

    // Both datapaths see every operand, the class bit picks one later
    barrel_shifter u_shifter (
        .d     (operand),
        .shift (shamt),
        .dir   (op[OP_DIR_BIT]),
        .mode  (op[OP_MODE_BIT]),
        .y     (shifted)
    );

    // Low code bits double as the count select
    bit_counter u_counter (
        .d     (operand),
        .sel   ({op[OP_MODE_BIT], op[OP_DIR_BIT]}),
        .count (count)
    );

    bit_result_select u_select (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .op      (op),
        .shifted (shifted),
        .count   (count),
        .result  (result),
        .zero    (zero),
        .done    (done)
    );

endmodule

// File: rtl/bit_width_pkg.sv
package bit_width_pkg;

    // Operand and result width
    localparam int WORD_BITS = 32;

    // A shift amount reaches WORD_BITS-1 at most
    localparam int SHAMT_BITS = $clog2(WORD_BITS);

    // One extra bit so a count can reach WORD_BITS itself
    localparam int COUNT_BITS = $clog2(WORD_BITS) + 1;

    typedef logic [WORD_BITS-1:0]  word_t;   // Operand or result word
    typedef logic [SHAMT_BITS-1:0] shamt_t;  // Shift or rotate distance
    typedef logic [COUNT_BITS-1:0] count_t;  // 0 to 32 inclusive

endpackage

// File: verif/bit_unit_assertions.sv
`timescale 1ns/1ps

module bit_unit_assertions (
    input logic                 clk,
    input logic                 reset,
    input logic                 start,
    input bit_width_pkg::word_t result,
    input logic                 zero,
    input logic                 done
);

    // Two done cycles in a row need two start cycles in a row
    assert property (@(posedge clk) disable iff (reset)
                     done && $past(done) |-> $past(start) && $past(start, 2))
        else $error("done high twice without start in both earlier cycles");

    assert property (@(posedge clk) disable iff (reset) start |=> done)
        else $error("done missing one cycle after start");

    assert property (@(posedge clk) disable iff (reset) !start |=> !done)
        else $error("done high without start in the previous cycle");

    // Synchronous clear
    assert property (@(posedge clk) reset |=> !done)
        else $error("done high after reset");

    assert property (@(posedge clk) disable iff (reset)
                     done |-> zero == (result == '0))
        else $error("zero flag disagrees with result");

endmodule

bind bit_unit bit_unit_assertions u_assertions (.*);

// File: verif/bit_unit_tb.sv
`timescale 1ns/1ps

module bit_unit_tb;

    import bit_width_pkg::*;
    import bit_op_pkg::*;

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] RAND_SEED    = 32'h0a65_574d;
    localparam int          RAND_WORDS   = 8;    // Random operands per count op
    localparam int          B2B_LEN      = 20;   // Consecutive start cycles
    localparam int          HOLD_CYCLES  = 3;

    // Cycle budget of each test for the watchdog
    localparam int SHIFT_CYCLES  = 2 * WORD_BITS + 2;
    localparam int ROTATE_CYCLES = 4 * WORD_BITS + 2;
    localparam int COUNT_CYCLES  = 3 * (2 + WORD_BITS + RAND_WORDS) + 4;
    localparam int B2B_CYCLES    = B2B_LEN + HOLD_CYCLES + 1;
    localparam int MARGIN_CYCLES = 50;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + 2 + SHIFT_CYCLES + ROTATE_CYCLES
                                 + COUNT_CYCLES + B2B_CYCLES + MARGIN_CYCLES;

    logic   clk;
    logic   reset;
    logic   start;
    op_t    op;
    word_t  operand;
    shamt_t shamt;
    word_t  result;
    logic   zero;
    logic   done;

    bit_unit DUT (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .op      (op),
        .operand (operand),
        .shamt   (shamt),
        .result  (result),
        .zero    (zero),
        .done    (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(word_t actual, word_t expected, string what);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t: %s, got %h expected %h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic check_flag(logic actual, logic expected, string what);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch at %0t: %s, got %b expected %b",
                               $time, what, actual, expected));
        end
    endtask

    function automatic int leading_zeros(word_t d);
        int n;
        n = 0;
        while (n < WORD_BITS && d[WORD_BITS-1-n] == 1'b0) begin
            n++;
        end
        return n;
    endfunction

    function automatic int trailing_zeros(word_t d);
        int n;
        n = 0;
        while (n < WORD_BITS && d[n] == 1'b0) begin
            n++;
        end
        return n;
    endfunction

    function automatic int set_bits(word_t d);
        int n;
        n = 0;
        foreach (d[i]) n += d[i];
        return n;
    endfunction

    // Expected result straight from the operation code table
    function automatic word_t model_result(op_t o, word_t d, shamt_t s);
        int n;
        n = s;
        case (o)
            OP_SLL:  return d << n;
            OP_SRL:  return d >> n;
            OP_ROL:  return (n == 0) ? d : ((d << n) | (d >> (WORD_BITS - n)));
            OP_ROR:  return (n == 0) ? d : ((d >> n) | (d << (WORD_BITS - n)));
            OP_CLZ:  return word_t'(leading_zeros(d));
            OP_CTZ:  return word_t'(trailing_zeros(d));
            default: return word_t'(set_bits(d));  // POP and reserved 111
        endcase
    endfunction

    task automatic drive_op(op_t o, word_t d, shamt_t s);
        start   = 1'b1;
        op      = o;
        operand = d;
        shamt   = s;
    endtask

    // One operation from one falling edge to the next
    task automatic run_op(op_t o, word_t d, shamt_t s);
        word_t expected;
        string tag;
        expected = model_result(o, d, s);
        tag      = $sformatf("op %b operand %h shamt %0d", o, d, s);
        drive_op(o, d, s);
        @(negedge clk);
        start = 1'b0;
        check_flag(done, 1'b1, {"done for ", tag});
        check_word(result, expected, {"result for ", tag});
        check_flag(zero, expected == '0, {"zero for ", tag});
    endtask

    task automatic reset_state();
        check_flag(done, 1'b0, "done after reset");
        check_word(result, '0, "result after reset");
        check_flag(zero, 1'b1, "zero after reset");
        @(negedge clk);
        check_flag(done, 1'b0, "done idle after reset");
    endtask

    task automatic shift_sweep();
        for (int n = 0; n < WORD_BITS; n++) begin
            run_op(OP_SLL, $urandom, shamt_t'(n));
            run_op(OP_SRL, $urandom, shamt_t'(n));
        end
        // Every set bit leaves the word
        run_op(OP_SLL, 32'hffff_fffe, 5'd31);
        check_flag(zero, 1'b1, "zero after SLL shifts all bits out");
        run_op(OP_SRL, 32'h7fff_ffff, 5'd31);
        check_flag(zero, 1'b1, "zero after SRL shifts all bits out");
    endtask

    task automatic rotate_sweep();
        word_t d;
        for (int n = 0; n < WORD_BITS; n++) begin
            run_op(OP_ROL, $urandom, shamt_t'(n));
            run_op(OP_ROR, $urandom, shamt_t'(n));
        end
        run_op(OP_ROL, 32'h1234_5678, 5'd16);
        check_word(result, 32'h5678_1234, "ROL by 16 swaps halves");
        run_op(OP_ROR, 32'h1234_5678, 5'd16);
        check_word(result, 32'h5678_1234, "ROR by 16 swaps halves");
        for (int n = 0; n < WORD_BITS; n++) begin
            d = $urandom;
            run_op(OP_ROL, d, shamt_t'(n));
            run_op(OP_ROR, result, shamt_t'(n));   // Undo the rotate
            check_word(result, d, $sformatf("ROL then ROR by %0d", n));
        end
    endtask

    task automatic count_patterns();
        word_t d;
        for (int k = 0; k < 2 + WORD_BITS + RAND_WORDS; k++) begin
            if (k == 0) begin
                d = '0;
            end else if (k == 1) begin
                d = '1;
            end else if (k < 2 + WORD_BITS) begin
                d = word_t'(1) << (k - 2);   // Single set bit
            end else begin
                d = $urandom;
            end
            run_op(OP_CLZ, d, '0);
            run_op(OP_CTZ, d, '0);
            run_op(OP_POP, d, '0);
        end
        run_op(3'b111, '0, '0);
        run_op(3'b111, '1, '0);
        run_op(3'b111, $urandom, '0);
        run_op(3'b111, 32'h8000_0001, '0);
        check_word(result, 32'd2, "reserved code counts the two set bits");
    endtask

    // Start held high while each falling edge checks the previous cycle's inputs
    task automatic back_to_back();
        word_t  exp_result;
        op_t    o;
        word_t  d;
        shamt_t s;
        o = OP_SLL;
        d = $urandom;
        s = shamt_t'($urandom);
        drive_op(o, d, s);
        exp_result = model_result(o, d, s);
        for (int i = 1; i <= B2B_LEN; i++) begin
            @(negedge clk);
            check_flag(done, 1'b1, $sformatf("done in back-to-back cycle %0d", i));
            check_word(result, exp_result, $sformatf("result in back-to-back cycle %0d", i));
            check_flag(zero, exp_result == '0, $sformatf("zero in back-to-back cycle %0d", i));
            if (i < B2B_LEN) begin
                o = op_t'(i);
                d = (i % 5 == 0) ? '0 : $urandom;
                s = shamt_t'($urandom);
                drive_op(o, d, s);
                exp_result = model_result(o, d, s);
            end else begin
                start = 1'b0;
            end
        end
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            check_flag(done, 1'b0, "done after start fell");
            check_word(result, exp_result, "result held after start fell");
            check_flag(zero, exp_result == '0, "zero held after start fell");
        end
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        clk     = 1'b0;
        reset   = 1'b1;
        start   = 1'b0;
        op      = OP_SLL;
        operand = '0;
        shamt   = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        reset_state();
        shift_sweep();
        rotate_sweep();
        count_patterns();
        back_to_back();

        $display("TB PASSED");
        $finish;
    end

    // Ends a hung run
    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD);
        fail_run("Watchdog timeout, the tests did not finish in time");
    end

endmodule
